// File: common/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

	// Serial bit timing in clock cycles, kept short for simulation
	localparam logic [15:0] CLKS_PER_BIT = 16'd8;

	// Start-bit edge to start-bit check
	localparam logic [15:0] HALF_BIT = CLKS_PER_BIT >> 1;

	// Data bits per frame, sent LSB first
	localparam int unsigned DATA_BITS = 8;

	// Entries per FIFO, must be a power of two
	localparam int unsigned FIFO_DEPTH = 4;

	// Index width into the FIFO storage
	localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// File: common/uart_types_pkg.sv
`default_nettype none

package uart_types_pkg;

	// One byte on the serial line
	typedef logic [7:0] uart_byte_t;

	// Received word as stored in the receive FIFO
	typedef struct packed {
		uart_byte_t data;
		// Stop bit was sampled low
		logic frame_err;
	} rx_word_t;

endpackage

`default_nettype wire

// File: dv/tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
();

	// Bytes sent over all tests set the watchdog limit
	localparam int TOTAL_BYTES = 38;
	localparam int TIMEOUT_NS = TOTAL_BYTES * 10 * CLKS_PER_BIT * 4 * 2 + 10 * 4;

	logic iCLOCK;
	logic inRESET;
	logic tx_valid;
	logic tx_ready;
	uart_byte_t tx_data;
	logic rx_valid;
	logic rx_ready;
	uart_byte_t rx_data;
	logic rx_frame_err;
	logic rx_overrun;
	logic uart_txd;
	logic uart_rxd;

	// Line source select between loopback and driven frames
	logic use_loopback;
	logic line_drv;
	logic tx_stalled;
	logic [31:0] lcg_state;
	int rx_count;
	int overrun_count;
	rx_word_t exp_q[$];

	assign uart_rxd = use_loopback ? uart_txd : line_drv;

	uart_top u_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_data(rx_data),
		.rx_frame_err(rx_frame_err),
		.rx_overrun(rx_overrun),
		.uart_txd(uart_txd),
		.uart_rxd(uart_rxd)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	function automatic logic [31:0] lcg_step(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Start bit, data LSB first, stop bit
	function automatic logic [9:0] expected_frame(uart_byte_t b);
		logic [9:0] f;
		f[0] = 1'b0;
		for (int i = 0; i < DATA_BITS; i++) begin
			f[i + 1] = b[i];
		end
		f[9] = 1'b1;
		return f;
	endfunction

	function automatic rx_word_t make_word(uart_byte_t b, logic err);
		rx_word_t w;
		w.data = b;
		w.frame_err = err;
		return w;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_word(string name, rx_word_t exp, rx_word_t act);
		if (exp !== act) begin
			abort_run($sformatf("** Error at %0d ns: %s expected %h actual %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_line_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			abort_run($sformatf("** Error at %0d ns: %s expected %b actual %b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (exp != act) begin
			abort_run($sformatf("** Error at %0d ns: %s expected %0d actual %0d",
				$time, name, exp, act));
		end
	endtask

	// Holds valid until the handshake edge
	task automatic send_byte(uart_byte_t b);
		tx_valid = 1'b1;
		tx_data = b;
		do begin
			@(posedge iCLOCK);
			if (!tx_ready) begin
				tx_stalled = 1'b1;
			end
		end while (!tx_ready);
		#1;
		tx_valid = 1'b0;
	endtask

	task automatic drive_frame(uart_byte_t b, logic stop_bit);
		logic [9:0] f;
		f = expected_frame(b);
		f[9] = stop_bit;
		for (int i = 0; i < 10; i++) begin
			line_drv = f[i];
			repeat (CLKS_PER_BIT) @(posedge iCLOCK);
			#1;
		end
		// One idle bit so a low stop bit is followed by a clean edge
		line_drv = 1'b1;
		repeat (CLKS_PER_BIT) @(posedge iCLOCK);
		#1;
	endtask

	task automatic next_byte(output uart_byte_t b);
		lcg_state = lcg_step(lcg_state);
		b = lcg_state[23:16];
	endtask

	task automatic wait_drained();
		do @(negedge iCLOCK); while (exp_q.size() != 0);
		@(posedge iCLOCK);
		#1;
	endtask

	always @(posedge iCLOCK) begin
		if (inRESET) begin
			if (rx_valid && rx_ready) begin
				if (exp_q.size() == 0) begin
					abort_run($sformatf("Unexpected word %h received at %0d ns", rx_data, $time));
				end else begin
					check_word("rx_word", exp_q.pop_front(), make_word(rx_data, rx_frame_err));
				end
				rx_count++;
			end
			if (rx_overrun) begin
				overrun_count++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("Timeout: the tests did not finish in time");
	end

	initial begin
		uart_byte_t b;
		logic [9:0] f;
		int start_words;
		int start_ovr;
		inRESET = 1'b0;
		tx_valid = 1'b0;
		tx_data = '0;
		rx_ready = 1'b1;
		use_loopback = 1'b1;
		line_drv = 1'b1;
		tx_stalled = 1'b0;
		lcg_state = 32'h8344;
		rx_count = 0;
		overrun_count = 0;
		repeat (10) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		@(posedge iCLOCK);
		#1;

		// Line format sampled mid-bit from the start edge
		next_byte(b);
		f = expected_frame(b);
		exp_q.push_back(make_word(b, 1'b0));
		send_byte(b);
		@(negedge uart_txd);
		repeat (HALF_BIT) @(posedge iCLOCK);
		#1;
		for (int i = 0; i < 10; i++) begin
			check_line_bit($sformatf("uart_txd bit %0d", i), f[i], uart_txd);
			repeat (CLKS_PER_BIT) @(posedge iCLOCK);
			#1;
		end
		wait_drained();

		// Loopback stream
		for (int i = 0; i < 20; i++) begin
			next_byte(b);
			exp_q.push_back(make_word(b, 1'b0));
			send_byte(b);
		end
		wait_drained();

		// Transmit back-pressure
		tx_stalled = 1'b0;
		for (int i = 0; i < 8; i++) begin
			next_byte(b);
			exp_q.push_back(make_word(b, 1'b0));
			send_byte(b);
		end
		if (!tx_stalled) begin
			abort_run("tx_ready never went low during the burst of 8 bytes");
		end
		wait_drained();

		// Framing error followed by a clean frame
		use_loopback = 1'b0;
		next_byte(b);
		exp_q.push_back(make_word(b, 1'b1));
		drive_frame(b, 1'b0);
		next_byte(b);
		exp_q.push_back(make_word(b, 1'b0));
		drive_frame(b, 1'b1);
		wait_drained();

		// Overrun with the host not reading
		rx_ready = 1'b0;
		start_words = rx_count;
		start_ovr = overrun_count;
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			next_byte(b);
			if (i < FIFO_DEPTH) begin
				exp_q.push_back(make_word(b, 1'b0));
			end
			drive_frame(b, 1'b1);
		end
		check_count("rx_overrun pulses", 2, overrun_count - start_ovr);
		rx_ready = 1'b1;
		wait_drained();
		check_count("words after overrun", FIFO_DEPTH, rx_count - start_words);

		// Glitch shorter than HALF_BIT before a real frame
		start_words = rx_count;
		line_drv = 1'b0;
		repeat (HALF_BIT / 2) @(posedge iCLOCK);
		#1;
		line_drv = 1'b1;
		repeat (2 * CLKS_PER_BIT) @(posedge iCLOCK);
		#1;
		next_byte(b);
		exp_q.push_back(make_word(b, 1'b0));
		drive_frame(b, 1'b1);
		wait_drained();
		repeat (2 * CLKS_PER_BIT) @(posedge iCLOCK);
		#1;
		check_count("words after glitch", 1, rx_count - start_words);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/uart_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module uart_assertions
	import uart_types_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic rx_valid,
	input logic rx_ready,
	input uart_byte_t rx_data,
	input logic rx_frame_err,
	input logic txq_valid,
	input logic txq_ready,
	input uart_byte_t txq_data,
	input logic rxw_valid,
	input logic rxw_ready,
	input logic uart_txd
);

	// Host side keeps its word until it is taken
	a_rx_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_frame_err))
		else $error("rx_valid dropped or payload changed before rx_ready");

	// Transmit FIFO output holds while the transmitter is busy
	a_txq_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		txq_valid && !txq_ready |=> txq_valid && $stable(txq_data))
		else $error("Transmit FIFO output changed before it was taken");

	// A refused word must leave the receive FIFO full
	a_rx_refused: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rxw_valid && !rxw_ready |=> !rxw_ready || rx_ready)
		else $error("Receive FIFO took a word while its ready was low");

	// Ready low only when the receive FIFO is full
	a_rx_full: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rxw_ready |-> rx_valid)
		else $error("Receive FIFO not ready while empty");

	a_txd_idle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		txq_ready |-> uart_txd)
		else $error("uart_txd low while the transmitter is idle");

endmodule

bind uart_top uart_assertions u_assertions (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.rx_valid(rx_valid),
	.rx_ready(rx_ready),
	.rx_data(rx_data),
	.rx_frame_err(rx_frame_err),
	.txq_valid(txq_valid),
	.txq_ready(txq_ready),
	.txq_data(txq_data),
	.rxw_valid(rxw_valid),
	.rxw_ready(rxw_ready),
	.uart_txd(uart_txd)
);

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_uart_top -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// File: src.f
common/uart_cfg_pkg.sv
common/uart_types_pkg.sv
verilog/stream_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
verilog/uart_top.sv
dv/uart_assertions.sv
dv/tb_uart_top.sv

// File: uart_rx/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic rxd,
	output logic word_valid,
	input logic word_ready,
	output rx_word_t word_data,
	output logic overrun
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CHECK,
		ST_DATA,
		ST_STOP
	} rx_state_t;

	// Two-flop synchronizer plus one flop for edge detect
	logic [1:0] rxd_sync;
	logic rxd_prev;
	logic rxd_s;
	logic fall;

	rx_state_t state;
	logic [15:0] bit_cnt;
	logic [$clog2(DATA_BITS)-1:0] bit_idx;
	uart_byte_t shreg;
	logic frame_err;
	logic sample;

	assign rxd_s = rxd_sync[1];
	assign fall = rxd_prev && !rxd_s;
	assign sample = (bit_cnt == CLKS_PER_BIT - 16'd1);

	assign word_data.data = shreg;
	assign word_data.frame_err = frame_err;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rxd_sync <= 2'b11;
			rxd_prev <= 1'b1;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_prev <= rxd_s;
		end
	end

	// Payload only, qualified by word_valid
	always_ff @(posedge iCLOCK) begin
		if (state == ST_DATA && sample) begin
			shreg <= {rxd_s, shreg[7:1]};
		end
		if (state == ST_STOP && sample) begin
			frame_err <= !rxd_s;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			word_valid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 16'd1;
			word_valid <= 1'b0;
			// No way to stall the line, so a refused word is lost
			overrun <= word_valid && !word_ready;
			case (state)
				ST_IDLE: begin
					if (fall) begin
						state <= ST_CHECK;
						bit_cnt <= '0;
					end
				end
				ST_CHECK: begin
					if (bit_cnt == HALF_BIT - 16'd1) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						// Line back high means a glitch
						state <= rxd_s ? ST_IDLE : ST_DATA;
					end
				end
				ST_DATA: begin
					if (sample) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == ($clog2(DATA_BITS))'(DATA_BITS - 1)) begin
							state <= ST_STOP;
						end
					end
				end
				ST_STOP: begin
					if (sample) begin
						state <= ST_IDLE;
						word_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic byte_valid,
	output logic byte_ready,
	input uart_byte_t byte_data,
	output logic txd
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} tx_state_t;

	tx_state_t state;
	logic [15:0] bit_cnt;
	logic [$clog2(DATA_BITS)-1:0] bit_idx;
	uart_byte_t shreg;
	logic bit_end;

	assign bit_end = (bit_cnt == CLKS_PER_BIT - 16'd1);
	assign byte_ready = (state == ST_IDLE);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			shreg <= '0;
			txd <= 1'b1;
		end else begin
			bit_cnt <= bit_cnt + 16'd1;
			case (state)
				ST_IDLE: begin
					txd <= 1'b1;
					if (byte_valid) begin
						state <= ST_START;
						shreg <= byte_data;
						bit_cnt <= '0;
						txd <= 1'b0;
					end
				end
				ST_START: begin
					if (bit_end) begin
						state <= ST_DATA;
						bit_cnt <= '0;
						bit_idx <= '0;
						txd <= shreg[0];
						shreg <= {1'b0, shreg[7:1]};
					end
				end
				ST_DATA: begin
					if (bit_end) begin
						bit_cnt <= '0;
						if (bit_idx == ($clog2(DATA_BITS))'(DATA_BITS - 1)) begin
							state <= ST_STOP;
							txd <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd <= shreg[0];
							shreg <= {1'b0, shreg[7:1]};
						end
					end
				end
				ST_STOP: begin
					// Idle cycle counts as the last stop cycle, so frames run back to back
					if (bit_cnt == CLKS_PER_BIT - 16'd2) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
	import uart_cfg_pkg::*;
#(
	parameter type payload_t = logic [7:0]
) (
	input logic iCLOCK,
	input logic inRESET,
	// Write side
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	// Read side
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	// Extra MSB tells full from empty
	logic [FIFO_PTR_W:0] wr_ptr;
	logic [FIFO_PTR_W:0] rd_ptr;
	payload_t mem [FIFO_DEPTH];

	logic empty;
	logic full;
	logic wr_en;
	logic rd_en;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
		(wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);

	// A read in the same cycle frees the slot for a write
	assign in_ready = !full || out_ready;
	assign out_valid = !empty;

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	assign out_data = mem[rd_ptr[FIFO_PTR_W-1:0]];

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_ptr[FIFO_PTR_W-1:0]] <= in_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top
	import uart_types_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	// Host transmit
	input logic tx_valid,
	output logic tx_ready,
	input uart_byte_t tx_data,
	// Host receive
	output logic rx_valid,
	input logic rx_ready,
	output uart_byte_t rx_data,
	output logic rx_frame_err,
	output logic rx_overrun,
	// Serial line
	output logic uart_txd,
	input logic uart_rxd
);

	// Transmit FIFO to transmitter
	logic txq_valid;
	logic txq_ready;
	uart_byte_t txq_data;

	// Receiver to receive FIFO
	logic rxw_valid;
	logic rxw_ready;
	rx_word_t rxw_data;

	rx_word_t rx_word;

	stream_fifo #(.payload_t(uart_byte_t)) u_tx_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(tx_valid),
		.in_ready(tx_ready),
		.in_data(tx_data),
		.out_valid(txq_valid),
		.out_ready(txq_ready),
		.out_data(txq_data)
	);

	uart_tx u_tx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.byte_valid(txq_valid),
		.byte_ready(txq_ready),
		.byte_data(txq_data),
		.txd(uart_txd)
	);

	uart_rx u_rx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.rxd(uart_rxd),
		.word_valid(rxw_valid),
		.word_ready(rxw_ready),
		.word_data(rxw_data),
		.overrun(rx_overrun)
	);

	stream_fifo #(.payload_t(rx_word_t)) u_rx_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(rxw_valid),
		.in_ready(rxw_ready),
		.in_data(rxw_data),
		.out_valid(rx_valid),
		.out_ready(rx_ready),
		.out_data(rx_word)
	);

	// Split the stored word onto the host ports
	assign rx_data = rx_word.data;
	assign rx_frame_err = rx_word.frame_err;

endmodule

`default_nettype wire
